/* bpc_state_top.f */
verilog/bpc_pkg.sv
verilog/bpc_band_regs.sv
verilog/bp_state_gen.sv
verilog/nmsedec_pipe.sv
verilog/bpc_state_top.sv
verif/bpc_state_chk.sv
verif/bpc_state_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run with Verilator, pass only when the pass line is printed
verilator --binary --assert -f bpc_state_top.f --top-module bpc_state_tb \
    -o bpc_state_sim \
    && ./obj_dir/bpc_state_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

/* verif/bpc_state_chk.sv */
`timescale 1ns/1ps
module bpc_state_chk (
    input  logic clk_rc,
    input  logic rst,
    input  logic [bpc_pkg::axi_addr_w-1:0] awaddr,
    input  logic awvalid,
    input  logic awready,
    input  logic [bpc_pkg::axi_data_w-1:0] wdata,
    input  logic wvalid,
    input  logic wready,
    input  logic [1:0] bresp,
    input  logic bvalid,
    input  logic bready,
    input  logic [bpc_pkg::axi_addr_w-1:0] araddr,
    input  logic arvalid,
    input  logic arready,
    input  logic [bpc_pkg::axi_data_w-1:0] rdata,
    input  logic [1:0] rresp,
    input  logic rvalid,
    input  logic rready,
    input  logic bp_step,
    input  logic stall,
    input  bpc_pkg::plane_t count_bp,
    input  bpc_pkg::coef_t [bpc_pkg::num_lanes-1:0] coef,
    input  bpc_pkg::pass_t [bpc_pkg::num_lanes-1:0] pass_type,
    input  logic [2:0] level,
    input  logic [1:0] comp,
    input  bpc_pkg::band_t band,
    input  bpc_pkg::plane_t top_plane,
    input  bpc_pkg::state_t [bpc_pkg::num_lanes-1:0] bp_state,
    input  bpc_pkg::dist_t [bpc_pkg::num_lanes-1:0] nmsedec
);

    import bpc_pkg::*;

    string test_name = "none";
    int err_count = 0;
    int check_count = 0;

    // five-deep model of the distortion pipeline, slot 0 is newest
    coef_t pipe_coef [5][num_lanes];
    plane_t pipe_plane [5];
    pass_t pipe_pass [5][num_lanes];
    dist_t exp_dist [num_lanes];
    coef_t cap_coef [num_lanes];
    count_t model_counts [128];
    logic [1:0] exp_bresp;
    logic [1:0] exp_rresp;
    logic [31:0] exp_rdata;
    logic wr_pending;
    logic rd_pending;
    logic exp_wr_ready;
    logic exp_rd_ready;

    function automatic logic entry_ok(int lvl, int cmp, int bnd);
        return (lvl <= max_level) && (cmp < num_comps) && (bnd != 0 || lvl == max_level);
    endfunction

    function automatic state_t state_ref(coef_t c, plane_t p);
        int msb;
        int pi;
        logic m;
        logic g;
        logic z;
        msb = 0;
        for (int b = 15; b >= min_plane; b--) begin
            if (c[b] && msb == 0) begin
                msb = b;
            end
        end
        pi = int'(p);
        z = (pi < msb);
        m = (pi >= min_plane) ? c[pi] : 1'b0;
        g = (msb >= fine_plane) && (pi <= msb - 2);
        return {c[16], m, g, z};
    endfunction

    function automatic dist_t dist_ref(coef_t c, plane_t p, pass_t ps, dist_t old);
        int w;
        int pi;
        int idx;
        int val;
        w = 0;
        pi = int'(p);
        if (pi >= min_plane) begin
            for (int j = 0; j < 7; j++) begin
                idx = pi - 6 + j;
                if (idx >= 0 && c[idx]) begin
                    w = w + (1 << j);
                end
            end
        end
        if (ps == pass_sig || ps == pass_cln) begin
            val = (pi > fine_plane) ? 384 * w - 18432 : 2 * w * w;
        end else if (ps == pass_ref) begin
            if (pi > fine_plane) begin
                val = (w >= 64) ? 128 * w - 10240 : 6144 - 128 * w;
            end else begin
                val = 2 * w * w - 256 * w + 8192;
            end
        end else begin
            return old;
        end
        return dist_t'(val);
    endfunction

    function automatic plane_t top_ref(count_t n, int lvl, int cmp, int bnd);
        if (!entry_ok(lvl, cmp, bnd)) begin
            return 4'd0;
        end
        return plane_t'((int'(n) + 3) % 16);
    endfunction

    function automatic int addr_entry(logic [11:0] a);
        return int'(a[8:2]);
    endfunction

    task automatic report_err(string what, int exp_v, int act_v);
        err_count++;
        $display("ERR %s %s expected %0d actual %0d", test_name, what, exp_v, act_v);
    endtask

    // model update at each clock edge
    always @(posedge clk_rc or negedge rst) begin
        int e;
        if (!rst) begin
            for (int s = 0; s < 5; s++) begin
                pipe_plane[s] = '0;
                for (int i = 0; i < num_lanes; i++) begin
                    pipe_coef[s][i] = '0;
                    pipe_pass[s][i] = pass_none;
                end
            end
            for (int i = 0; i < num_lanes; i++) begin
                exp_dist[i] = '0;
                cap_coef[i] = '0;
            end
            for (int k = 0; k < 128; k++) begin
                model_counts[k] = '0;
            end
            exp_bresp = resp_okay;
            exp_rresp = resp_okay;
            exp_rdata = '0;
            wr_pending = 1'b0;
            rd_pending = 1'b0;
        end else begin
            if (bp_step && !stall) begin
                for (int i = 0; i < num_lanes; i++) begin
                    exp_dist[i] = dist_ref(pipe_coef[4][i], pipe_plane[4],
                                           pipe_pass[4][i], exp_dist[i]);
                end
                for (int s = 4; s > 0; s--) begin
                    pipe_plane[s] = pipe_plane[s-1];
                    for (int i = 0; i < num_lanes; i++) begin
                        pipe_coef[s][i] = pipe_coef[s-1][i];
                        pipe_pass[s][i] = pipe_pass[s-1][i];
                    end
                end
                pipe_plane[0] = count_bp;
                for (int i = 0; i < num_lanes; i++) begin
                    pipe_coef[0][i] = coef[i];
                    pipe_pass[0][i] = pass_type[i];
                    cap_coef[i] = coef[i];
                end
            end
            // ready only while no response is outstanding
            exp_wr_ready = awvalid && wvalid && !wr_pending;
            exp_rd_ready = arvalid && !rd_pending;
            check_count++;
            if (awready !== exp_wr_ready) begin
                report_err("awready", int'(exp_wr_ready), int'(awready));
            end
            if (wready !== exp_wr_ready) begin
                report_err("wready", int'(exp_wr_ready), int'(wready));
            end
            if (bvalid !== wr_pending) begin
                report_err("bvalid", int'(wr_pending), int'(bvalid));
            end
            if (arready !== exp_rd_ready) begin
                report_err("arready", int'(exp_rd_ready), int'(arready));
            end
            if (rvalid !== rd_pending) begin
                report_err("rvalid", int'(rd_pending), int'(rvalid));
            end
            if (bvalid && bready) begin
                check_count++;
                if (bresp !== exp_bresp) begin
                    report_err("bresp", int'(exp_bresp), int'(bresp));
                end
            end
            if (rvalid && rready) begin
                check_count++;
                if (rresp !== exp_rresp) begin
                    report_err("rresp", int'(exp_rresp), int'(rresp));
                end
                if (rdata !== exp_rdata) begin
                    report_err("rdata", int'(exp_rdata), int'(rdata));
                end
            end
            if (exp_wr_ready) begin
                wr_pending = 1'b1;
                e = addr_entry(awaddr);
                if (entry_ok(e / 16, (e / 4) % 4, e % 4)) begin
                    model_counts[e] = wdata[3:0];
                    exp_bresp = resp_okay;
                end else begin
                    exp_bresp = resp_slverr;
                end
            end else if (bready) begin
                wr_pending = 1'b0;
            end
            if (exp_rd_ready) begin
                rd_pending = 1'b1;
                e = addr_entry(araddr);
                if (entry_ok(e / 16, (e / 4) % 4, e % 4)) begin
                    exp_rdata = {28'd0, model_counts[e]};
                    exp_rresp = resp_okay;
                end else begin
                    exp_rdata = '0;
                    exp_rresp = resp_slverr;
                end
            end else if (rready) begin
                rd_pending = 1'b0;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk_rc) begin
        state_t st;
        plane_t tp;
        if (rst) begin
            for (int i = 0; i < num_lanes; i++) begin
                st = state_ref(cap_coef[i], count_bp);
                check_count++;
                if (bp_state[i] !== st) begin
                    report_err($sformatf("bp_state[%0d]", i), int'(st), int'(bp_state[i]));
                end
                check_count++;
                if (nmsedec[i] !== exp_dist[i]) begin
                    report_err($sformatf("nmsedec[%0d]", i), int'(exp_dist[i]),
                               int'(nmsedec[i]));
                end
            end
            tp = top_ref(model_counts[{level, comp, band}], int'(level), int'(comp),
                         int'(band));
            check_count++;
            if (top_plane !== tp) begin
                report_err("top_plane", int'(tp), int'(top_plane));
            end
        end
    end

endmodule

/* verif/bpc_state_tb.sv */
`timescale 1ns/1ps
module bpc_state_tb;

    import bpc_pkg::*;

    localparam int timeout_cycles = 6000;

    logic clk_rc = 1'b0;
    logic rst = 1'b0;
    logic [axi_addr_w-1:0] awaddr = '0;
    logic awvalid = 1'b0;
    logic awready;
    logic [axi_data_w-1:0] wdata = '0;
    logic wvalid = 1'b0;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready = 1'b0;
    logic [axi_addr_w-1:0] araddr = '0;
    logic arvalid = 1'b0;
    logic arready;
    logic [axi_data_w-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready = 1'b0;
    logic bp_step = 1'b0;
    logic stall = 1'b0;
    plane_t count_bp = '0;
    coef_t [num_lanes-1:0] coef = '0;
    pass_t [num_lanes-1:0] pass_type = {num_lanes{pass_none}};
    logic [2:0] level = '0;
    logic [1:0] comp = '0;
    band_t band = band_ll;
    plane_t top_plane;
    state_t [num_lanes-1:0] bp_state;
    dist_t [num_lanes-1:0] nmsedec;

    logic [31:0] rng = 32'h6348_6a66;
    int cycle_count = 0;
    int errs_before = 0;

    bpc_state_top bpc_state_top_inst (.*);
    bpc_state_chk bpc_state_chk_inst (.*);

    initial begin
        forever #50 clk_rc = ~clk_rc;
    end

    always @(posedge clk_rc) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // sparse magnitudes land near the plane limits
    function automatic coef_t make_coef();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0: return coef_t'(r[31:15]);
            2'd1: return {r[2], 16'(32'd1 << r[7:4])};
            2'd2: return {r[2], 12'd0, r[11:8]};
            default: return {r[2], 16'(32'd1 << (3 + int'(r[5:4]))) | 16'(r[13:8])};
        endcase
    endfunction

    function automatic pass_t pick_pass(logic [1:0] r);
        case (r)
            2'd0: return pass_none;
            2'd1: return pass_sig;
            2'd2: return pass_ref;
            default: return pass_cln;
        endcase
    endfunction

    task automatic drive_lanes();
        logic [31:0] r;
        r = next_rand();
        count_bp = r[3:0];
        for (int i = 0; i < num_lanes; i++) begin
            coef[i] = make_coef();
            pass_type[i] = pick_pass(r[5 + 2*i -: 2]);
        end
    endtask

    task automatic axi_write(int entry, logic [31:0] data);
        int gap;
        gap = int'(next_rand() % 32'd3);
        @(posedge clk_rc);
        #5;
        awaddr = 12'(entry << 2);
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b0;
        @(negedge clk_rc);
        while (!awready) @(negedge clk_rc);
        @(posedge clk_rc);
        #5;
        awvalid = 1'b0;
        wvalid = 1'b0;
        // response held back a few cycles
        repeat (gap) begin
            @(posedge clk_rc);
            #5;
        end
        bready = 1'b1;
        @(negedge clk_rc);
        while (!bvalid) @(negedge clk_rc);
        @(posedge clk_rc);
    endtask

    task automatic axi_read(int entry);
        int gap;
        gap = int'(next_rand() % 32'd3);
        @(posedge clk_rc);
        #5;
        araddr = 12'(entry << 2);
        arvalid = 1'b1;
        rready = 1'b0;
        @(negedge clk_rc);
        while (!arready) @(negedge clk_rc);
        @(posedge clk_rc);
        #5;
        arvalid = 1'b0;
        // read data held back a few cycles
        repeat (gap) begin
            @(posedge clk_rc);
            #5;
        end
        rready = 1'b1;
        @(negedge clk_rc);
        while (!rvalid) @(negedge clk_rc);
        @(posedge clk_rc);
    endtask

    task automatic start_test(string name);
        bpc_state_chk_inst.test_name = name;
        errs_before = bpc_state_chk_inst.err_count;
    endtask

    task automatic finish_test(string name);
        $display("test %s done with %0d errors", name, bpc_state_chk_inst.err_count - errs_before);
    endtask

    function automatic logic valid_entry(int e);
        return (e / 16 <= max_level) && ((e / 4) % 4 < num_comps) &&
               (e % 4 != 0 || e / 16 == max_level);
    endfunction

    initial begin
        int adv;
        logic [31:0] r;
        repeat (4) @(posedge clk_rc);
        #5;
        rst = 1'b1;

        start_test("reset");
        for (int e = 0; e < 128; e += 5) begin
            if (valid_entry(e)) axi_read(e);
        end
        finish_test("reset");

        start_test("registers");
        for (int e = 0; e < 128; e++) begin
            if (valid_entry(e)) axi_write(e, next_rand());
        end
        for (int e = 0; e < 128; e++) begin
            if (valid_entry(e)) axi_read(e);
        end
        // level 5, comp 3, LL at level 0
        axi_write(5 * 16 + 1, 32'h5);
        axi_read(5 * 16 + 1);
        axi_write(3 * 4 + 2, 32'h6);
        axi_read(3 * 4 + 2);
        axi_write(0, 32'h7);
        axi_read(0);
        finish_test("registers");

        start_test("top_plane");
        for (int e = 0; e < 128; e++) begin
            @(posedge clk_rc);
            #5;
            {level, comp} = 5'(e >> 2);
            band = band_t'(e % 4);
        end
        finish_test("top_plane");

        start_test("state");
        for (int n = 0; n < 200; n++) begin
            @(posedge clk_rc);
            #5;
            bp_step = 1'b1;
            drive_lanes();
            if (n % 4 == 3) begin
                // live plane changes between advances
                @(posedge clk_rc);
                #5;
                bp_step = 1'b0;
                count_bp = plane_t'(next_rand());
            end
        end
        @(posedge clk_rc);
        #5;
        bp_step = 1'b0;
        finish_test("state");

        start_test("dist_stall");
        adv = 0;
        while (adv < 300) begin
            @(posedge clk_rc);
            #5;
            r = next_rand();
            bp_step = (r[1:0] != 2'd0);
            stall = (r[4:2] == 3'd0);
            drive_lanes();
            if (bp_step && !stall) adv++;
        end
        @(posedge clk_rc);
        #5;
        bp_step = 1'b0;
        stall = 1'b0;
        repeat (3) @(posedge clk_rc);
        finish_test("dist_stall");

        $display("checks %0d errors %0d", bpc_state_chk_inst.check_count,
                 bpc_state_chk_inst.err_count);
        if (bpc_state_chk_inst.err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/bp_state_gen.sv */
`timescale 1ns/1ps
module bp_state_gen (
    input  logic clk_rc,
    input  logic rst,
    input  logic bp_step,
    input  logic stall,
    input  bpc_pkg::plane_t count_bp,
    input  bpc_pkg::coef_t [bpc_pkg::num_lanes-1:0] coef,
    output bpc_pkg::state_t [bpc_pkg::num_lanes-1:0] bp_state
);

    import bpc_pkg::*;

    logic advance;
    coef_t [num_lanes-1:0] coef_q;

    // highest set magnitude bit, 0 when below min_plane
    function automatic plane_t msb_of(logic [15:0] mag);
        plane_t pos;
        pos = '0;
        for (int b = min_plane; b < 16; b++) begin
            if (mag[b]) begin
                pos = plane_t'(b);
            end
        end
        return pos;
    endfunction

    assign advance = bp_step && !stall;

    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            coef_q <= '0;
        end else if (advance) begin
            coef_q <= coef;
        end
    end

    // state follows the live plane counter
    always_comb begin
        plane_t msb;
        logic mag_bit;
        logic gamma_bit;
        logic sigma_bit;
        for (int i = 0; i < num_lanes; i++) begin
            msb = msb_of(coef_q[i][15:0]);
            sigma_bit = (count_bp < msb);
            if (count_bp >= min_plane) begin
                mag_bit = coef_q[i][count_bp];
            end else begin
                mag_bit = 1'b0;
            end
            // refinement only two planes below the msb
            if (msb < fine_plane) begin
                gamma_bit = 1'b0;
            end else if (count_bp > msb - 4'd2) begin
                gamma_bit = 1'b0;
            end else begin
                gamma_bit = 1'b1;
            end
            bp_state[i] = {coef_q[i][16], mag_bit, gamma_bit, sigma_bit};
        end
    end

endmodule

/* verilog/bpc_band_regs.sv */
`timescale 1ns/1ps
module bpc_band_regs (
    input  logic clk_rc,
    input  logic rst,
    input  logic [bpc_pkg::axi_addr_w-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [bpc_pkg::axi_data_w-1:0] wdata,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [bpc_pkg::axi_addr_w-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [bpc_pkg::axi_data_w-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    input  logic [2:0] level,
    input  logic [1:0] comp,
    input  bpc_pkg::band_t band,
    output bpc_pkg::plane_t top_plane
);

    import bpc_pkg::*;

    // one count per {level, comp, band}
    count_t counts [2**entry_w];

    logic [entry_w-1:0] wr_idx;
    logic [entry_w-1:0] rd_idx;
    logic [entry_w-1:0] lk_idx;
    logic wr_fire;
    logic rd_fire;

    // LL exists only at the deepest level
    function automatic logic entry_valid(logic [entry_w-1:0] idx);
        logic [2:0] lvl;
        logic [1:0] cmp;
        logic [1:0] bnd;
        lvl = idx[6:4];
        cmp = idx[3:2];
        bnd = idx[1:0];
        return (lvl <= max_level) && (cmp < num_comps) &&
               ((bnd != band_ll) || (lvl == max_level));
    endfunction

    // word address is byte address [8:2]
    assign wr_idx = awaddr[8:2];
    assign rd_idx = araddr[8:2];
    assign lk_idx = {level, comp, band};

    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready = wr_fire;

    assign rd_fire = arvalid && !rvalid;
    assign arready = rd_fire;

    // write channel and count storage
    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 2**entry_w; i++) begin
                counts[i] <= '0;
            end
            bvalid <= 1'b0;
            bresp <= resp_okay;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            if (entry_valid(wr_idx)) begin
                counts[wr_idx] <= wdata[$bits(count_t)-1:0];
                bresp <= resp_okay;
            end else begin
                bresp <= resp_slverr;
            end
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // read channel
    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            rvalid <= 1'b0;
            rdata <= '0;
            rresp <= resp_okay;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
            if (entry_valid(rd_idx)) begin
                rdata <= {{(axi_data_w - $bits(count_t)){1'b0}}, counts[rd_idx]};
                rresp <= resp_okay;
            end else begin
                rdata <= '0;
                rresp <= resp_slverr;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // top plane wraps modulo 16
    assign top_plane = entry_valid(lk_idx) ? counts[lk_idx] + 4'd3 : '0;

    bvalid_hold: assert property (
        @(posedge clk_rc) disable iff (!rst)
        (bvalid && !bready) |=> bvalid
    );

    rvalid_hold: assert property (
        @(posedge clk_rc) disable iff (!rst)
        (rvalid && !rready) |=> rvalid
    );

endmodule

/* verilog/bpc_pkg.sv */
package bpc_pkg;

    // stripe column geometry
    localparam int num_lanes = 4;

    // plane limits
    localparam int min_plane = 4;
    localparam int fine_plane = 6;

    // subband layout
    localparam int max_level = 4;
    localparam int num_comps = 3;
    localparam int entry_w = 7;

    // AXI4-Lite slave
    localparam int axi_addr_w = 12;
    localparam int axi_data_w = 32;
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // sign in bit 16, magnitude below
    typedef logic [16:0] coef_t;
    typedef logic [3:0] plane_t;
    // {sign, mag, gamma, sigma}
    typedef logic [3:0] state_t;
    typedef logic signed [16:0] dist_t;
    typedef logic [6:0] window_t;
    typedef logic [13:0] square_t;
    typedef logic [3:0] count_t;

    typedef enum logic [2:0] {
        pass_none = 3'b000,
        pass_sig = 3'b001,
        pass_ref = 3'b010,
        pass_cln = 3'b100
    } pass_t;

    typedef enum logic [1:0] {
        band_ll = 2'd0,
        band_hl = 2'd1,
        band_lh = 2'd2,
        band_hh = 2'd3
    } band_t;

endpackage

/* verilog/bpc_state_top.sv */
`timescale 1ns/1ps
module bpc_state_top (
    input  logic clk_rc,
    input  logic rst,
    // AXI4-Lite slave
    input  logic [bpc_pkg::axi_addr_w-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [bpc_pkg::axi_data_w-1:0] wdata,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [bpc_pkg::axi_addr_w-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [bpc_pkg::axi_data_w-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    // coder side
    input  logic bp_step,
    input  logic stall,
    input  bpc_pkg::plane_t count_bp,
    input  bpc_pkg::coef_t [bpc_pkg::num_lanes-1:0] coef,
    input  bpc_pkg::pass_t [bpc_pkg::num_lanes-1:0] pass_type,
    input  logic [2:0] level,
    input  logic [1:0] comp,
    input  bpc_pkg::band_t band,
    output bpc_pkg::plane_t top_plane,
    output bpc_pkg::state_t [bpc_pkg::num_lanes-1:0] bp_state,
    output bpc_pkg::dist_t [bpc_pkg::num_lanes-1:0] nmsedec
);

    bpc_band_regs bpc_band_regs_inst (
        .clk_rc    (clk_rc),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .level     (level),
        .comp      (comp),
        .band      (band),
        .top_plane (top_plane)
    );

    bp_state_gen bp_state_gen_inst (
        .clk_rc   (clk_rc),
        .rst      (rst),
        .bp_step  (bp_step),
        .stall    (stall),
        .count_bp (count_bp),
        .coef     (coef),
        .bp_state (bp_state)
    );

    nmsedec_pipe nmsedec_pipe_inst (
        .clk_rc    (clk_rc),
        .rst       (rst),
        .bp_step   (bp_step),
        .stall     (stall),
        .count_bp  (count_bp),
        .coef      (coef),
        .pass_type (pass_type),
        .nmsedec   (nmsedec)
    );

endmodule

/* verilog/nmsedec_pipe.sv */
`timescale 1ns/1ps
module nmsedec_pipe (
    input  logic clk_rc,
    input  logic rst,
    input  logic bp_step,
    input  logic stall,
    input  bpc_pkg::plane_t count_bp,
    input  bpc_pkg::coef_t [bpc_pkg::num_lanes-1:0] coef,
    input  bpc_pkg::pass_t [bpc_pkg::num_lanes-1:0] pass_type,
    output bpc_pkg::dist_t [bpc_pkg::num_lanes-1:0] nmsedec
);

    import bpc_pkg::*;

    logic advance;

    // plane and pass ride along with their coefficient
    coef_t [num_lanes-1:0] s1_coef;
    coef_t [num_lanes-1:0] s2_coef;
    window_t [num_lanes-1:0] s3_w;
    window_t [num_lanes-1:0] s4_w;
    window_t [num_lanes-1:0] s5_w;
    square_t [num_lanes-1:0] s5_q;
    plane_t s1_plane;
    plane_t s2_plane;
    plane_t s3_plane;
    plane_t s4_plane;
    plane_t s5_plane;
    pass_t [num_lanes-1:0] s1_pass;
    pass_t [num_lanes-1:0] s2_pass;
    pass_t [num_lanes-1:0] s3_pass;
    pass_t [num_lanes-1:0] s4_pass;
    pass_t [num_lanes-1:0] s5_pass;

    // seven magnitude bits from the plane down, zero-filled under bit 0
    function automatic window_t window_of(coef_t c, plane_t p);
        logic [21:0] ext;
        ext = {c[15:0], 6'b0} >> p;
        if (p < min_plane) begin
            return '0;
        end
        return ext[6:0];
    endfunction

    function automatic dist_t dist_calc(window_t w, square_t q, plane_t p, pass_t ps,
                                        dist_t old);
        int wi;
        int qi;
        int val;
        wi = int'(w);
        qi = int'(q);
        val = 0;
        case (ps)
            pass_sig, pass_cln: begin
                if (p > fine_plane) begin
                    val = 384 * wi - 18432;
                end else begin
                    val = 2 * qi;
                end
            end
            pass_ref: begin
                if (p > fine_plane) begin
                    val = (wi >= 64) ? 128 * wi - 10240 : 6144 - 128 * wi;
                end else begin
                    val = 2 * qi - 256 * wi + 8192;
                end
            end
            default: begin
                return old;
            end
        endcase
        return dist_t'(val);
    endfunction

    assign advance = bp_step && !stall;

    // stages 1 and 2: capture and delay
    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            s1_coef <= '0;
            s2_coef <= '0;
            s1_plane <= '0;
            s2_plane <= '0;
            for (int i = 0; i < num_lanes; i++) begin
                s1_pass[i] <= pass_none;
                s2_pass[i] <= pass_none;
            end
        end else if (advance) begin
            s1_coef <= coef;
            s1_plane <= count_bp;
            s1_pass <= pass_type;
            s2_coef <= s1_coef;
            s2_plane <= s1_plane;
            s2_pass <= s1_pass;
        end
    end

    // stages 3 and 4: window, then delay
    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            s3_w <= '0;
            s4_w <= '0;
            s3_plane <= '0;
            s4_plane <= '0;
            for (int i = 0; i < num_lanes; i++) begin
                s3_pass[i] <= pass_none;
                s4_pass[i] <= pass_none;
            end
        end else if (advance) begin
            for (int i = 0; i < num_lanes; i++) begin
                s3_w[i] <= window_of(s2_coef[i], s2_plane);
            end
            s3_plane <= s2_plane;
            s3_pass <= s2_pass;
            s4_w <= s3_w;
            s4_plane <= s3_plane;
            s4_pass <= s3_pass;
        end
    end

    // stage 5 squares, output applies the pass formula
    always_ff @(posedge clk_rc or negedge rst) begin
        if (!rst) begin
            s5_w <= '0;
            s5_q <= '0;
            s5_plane <= '0;
            nmsedec <= '0;
            for (int i = 0; i < num_lanes; i++) begin
                s5_pass[i] <= pass_none;
            end
        end else if (advance) begin
            for (int i = 0; i < num_lanes; i++) begin
                s5_q[i] <= s4_w[i] * s4_w[i];
                nmsedec[i] <= dist_calc(s5_w[i], s5_q[i], s5_plane, s5_pass[i], nmsedec[i]);
            end
            s5_w <= s4_w;
            s5_plane <= s4_plane;
            s5_pass <= s4_pass;
        end
    end

    for (genvar g = 0; g < num_lanes; g++) begin : g_pass_chk
        pass_code: assert property (
            @(posedge clk_rc) disable iff (!rst)
            (bp_step && !stall) |->
                pass_type[g] inside {pass_none, pass_sig, pass_ref, pass_cln}
        );
    end

endmodule
